// File: verilog.f
+incdir+include
logic/anc_pkg.sv
logic/frame_sequencer.sv
logic/tap_delay_line.sv
logic/lms_channel.sv
logic/cancel_output.sv
logic/anc_top.sv
testbench/anc_props.sv
testbench/anc_tb.sv

// File: Makefile
# Verilator simulation of the adaptive noise canceller

VERILATOR ?= verilator
TOP       ?= anc_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# The testbench ends every failing run with $fatal, so the binary exit status is the verdict
sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/anc_tb.sv
`timescale 1ns/1ps
`include "anc_defines.svh"

module anc_tb import anc_pkg::*;
();

    localparam int FRAME_HIGH  = 2 * `ANC_TAPS + 6;
    localparam int FRAME_LOW   = 2;
    localparam int OUT_EDGE    = `ANC_TAPS + 2;
    localparam int MAX_FRAMES  = 110;
    localparam int CYCLE_LIMIT = MAX_FRAMES * 80 + 400;

    logic    clk;
    logic    rstn;
    logic    head_flag;
    sample_t prim_a;
    sample_t prim_b;
    sample_t ref_in;
    sample_t dout;
    int      cycles;

    // Reference model state
    int m_ref [`ANC_TAPS];
    int m_pa [`ANC_PRIM_DELAY];
    int m_pb [`ANC_PRIM_DELAY];
    int m_w [2][`ANC_TAPS];
    int m_dout;

    anc_top uut (
        .clk       (clk),
        .rstn      (rstn),
        .head_flag (head_flag),
        .prim_a    (prim_a),
        .prim_b    (prim_b),
        .ref_in    (ref_in),
        .dout      (dout)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("=== FAIL ===");
            $fatal(1, "Timeout, the run went past %0d clock cycles", CYCLE_LIMIT);
        end
    end

    function automatic int wrap_sample(input longint v);
        logic signed [`ANC_SAMPLE_W-1:0] t;
        t = v[`ANC_SAMPLE_W-1:0];
        return int'(t);
    endfunction

    function automatic int channel_error(input int ch, input int prim);
        longint sum;
        sum = 0;
        for (int k = 0; k < `ANC_TAPS; k++)
        begin
            sum = sum + longint'(m_w[ch][k]) * longint'(m_ref[k]);
        end
        return wrap_sample(longint'(prim) - longint'(wrap_sample(sum >>> `ANC_W_FRAC)));
    endfunction

    function automatic void adapt_weights(input int ch, input int e);
        for (int k = 0; k < `ANC_TAPS; k++)
        begin
            m_w[ch][k] = m_w[ch][k] + ((e * m_ref[k]) >>> `ANC_MU_SHIFT);  // int wraps at 32 bits
        end
    endfunction

    function automatic void model_reset();
        for (int k = 0; k < `ANC_TAPS; k++)
        begin
            m_ref[k]  = 0;
            m_w[0][k] = 0;
            m_w[1][k] = 0;
        end
        for (int k = 0; k < `ANC_PRIM_DELAY; k++)
        begin
            m_pa[k] = 0;
            m_pb[k] = 0;
        end
        m_dout = 0;
    endfunction

    function automatic void model_frame(input int pa, input int pb, input int rf);
        int ea;
        int eb;
        for (int k = `ANC_TAPS - 1; k > 0; k--)
        begin
            m_ref[k] = m_ref[k-1];
        end
        m_ref[0] = rf;
        ea = channel_error(0, m_pa[`ANC_PRIM_DELAY-1]);
        eb = channel_error(1, m_pb[`ANC_PRIM_DELAY-1]);
        m_dout = wrap_sample(longint'(ea + eb));
        for (int k = `ANC_PRIM_DELAY - 1; k > 0; k--)
        begin
            m_pa[k] = m_pa[k-1];
            m_pb[k] = m_pb[k-1];
        end
        m_pa[0] = pa;
        m_pb[0] = pb;
        adapt_weights(0, ea);
        adapt_weights(1, eb);
    endfunction

    task automatic check_value(input string what, input int got, input int exp);
        if (got != exp)
        begin
            $display("error at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "Mismatch");
        end
    endtask

    // Starts 1 ns after an edge and ends 1 ns after an edge
    task automatic run_frame(input int pa, input int pb, input int rf);
        int old_dout;
        old_dout = m_dout;
        model_frame(pa, pb, rf);
        head_flag = 1'b1;
        prim_a    = sample_t'(pa);
        prim_b    = sample_t'(pb);
        ref_in    = sample_t'(rf);
        for (int i = 0; i < FRAME_HIGH; i++)
        begin
            @(posedge clk);
            #1;
            if (i < OUT_EDGE)
                check_value("dout before the ERROR edge", int'(dout), old_dout);
            else
                check_value("dout after the ERROR edge", int'(dout), m_dout);
        end
        head_flag = 1'b0;
        repeat (FRAME_LOW)
        begin
            @(posedge clk);
            #1;
            check_value("dout between frames", int'(dout), m_dout);
        end
    endtask

    task automatic apply_reset();
        rstn      = 1'b0;
        head_flag = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        model_reset();
    endtask

    task automatic test_reset_idle();
        repeat (10)
        begin
            @(posedge clk);
            #1;
            check_value("dout in idle after reset", int'(dout), 0);
        end
    endtask

    task automatic test_zero_reference();
        for (int f = 0; f < 20; f++)
        begin
            run_frame((f % 2) ? 8191 - f : -8192 + f, (f % 3) ? 8190 : -8191, 0);
            if (f < `ANC_PRIM_DELAY)
                check_value("dout before the primary delay fills", int'(dout), 0);
        end
    endtask

    task automatic test_random_frames(input int n);
        for (int f = 0; f < n; f++)
        begin
            run_frame(wrap_sample($urandom), wrap_sample($urandom), wrap_sample($urandom));
        end
    endtask

    task automatic test_dout_hold();
        run_frame(1234, -4321, 777);
        repeat (20)
        begin
            @(posedge clk);
            #1;
            check_value("dout in long idle", int'(dout), m_dout);
        end
        run_frame(-100, 200, -300);
    endtask

    task automatic test_reset_mid_frame();
        head_flag = 1'b1;
        prim_a    = sample_t'(555);
        prim_b    = sample_t'(-666);
        ref_in    = sample_t'(999);
        repeat (20) @(posedge clk);
        #1;
        rstn = 1'b0;
        #1;
        check_value("dout right after reset assertion", int'(dout), 0);
        repeat (8) @(posedge clk);
        #1;
        head_flag = 1'b0;
        @(posedge clk);
        #1;
        rstn = 1'b1;
        model_reset();
        check_value("dout after mid-frame reset", int'(dout), 0);
        test_random_frames(20);
    endtask

    initial
    begin
        void'($urandom(32'hfa74cd65));
        cycles    = 0;
        rstn      = 1'b0;
        head_flag = 1'b0;
        prim_a    = '0;
        prim_b    = '0;
        ref_in    = '0;
        model_reset();
        apply_reset();
        test_reset_idle();
        test_zero_reference();
        test_random_frames(60);
        test_dout_hold();
        test_reset_mid_frame();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: testbench/anc_props.sv
`timescale 1ns/1ps
`include "anc_defines.svh"

module anc_props import anc_pkg::*;
(
    input logic      clk,
    input logic      rstn,
    input anc_ctrl_t ctrl,
    input sample_t   dout
);

    localparam logic [`ANC_IDX_W-1:0] LAST_IDX = `ANC_IDX_W'(`ANC_TAPS - 1);

    logic in_frame;  // Set by the shift, cleared when the frame reaches ERROR

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            in_frame <= 1'b0;
        end
        else if (ctrl.shift)
        begin
            in_frame <= 1'b1;
        end
        else if (ctrl.latch_err)
        begin
            in_frame <= 1'b0;
        end
    end

    a_one_shift: assert property (@(posedge clk) disable iff (!rstn)
        ctrl.shift |-> !in_frame)
        else $error("second shift inside one frame");

    a_err_after_shift: assert property (@(posedge clk) disable iff (!rstn)
        ctrl.latch_err |-> in_frame)
        else $error("error latch without a preceding shift");

    a_phase_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(ctrl.mac_en && ctrl.adapt_en))
        else $error("mac_en and adapt_en high together");

    // A phase walks the taps from 0 up to the last one and then ends
    a_tap_start: assert property (@(posedge clk) disable iff (!rstn)
        $rose(ctrl.mac_en) || $rose(ctrl.adapt_en) |-> ctrl.tap_idx == '0)
        else $error("phase did not start at tap 0");

    a_tap_step: assert property (@(posedge clk) disable iff (!rstn)
        (ctrl.mac_en && $past(ctrl.mac_en)) || (ctrl.adapt_en && $past(ctrl.adapt_en))
        |-> ctrl.tap_idx == $past(ctrl.tap_idx) + 1'b1)
        else $error("tap index did not advance by one inside a phase");

    a_tap_range: assert property (@(posedge clk) disable iff (!rstn)
        $fell(ctrl.mac_en) || $fell(ctrl.adapt_en) |-> $past(ctrl.tap_idx) == LAST_IDX)
        else $error("phase ended before the last tap or ran past it");

    a_dout_stable: assert property (@(posedge clk) disable iff (!rstn)
        $changed(dout) |-> $past(ctrl.latch_err))
        else $error("dout changed outside the ERROR edge");

endmodule

bind anc_top anc_props u_props (
    .clk  (clk),
    .rstn (rstn),
    .ctrl (ctrl),
    .dout (dout)
);

// File: logic/anc_top.sv
`timescale 1ns/1ps
`include "anc_defines.svh"

module anc_top import anc_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  logic    head_flag,
    input  sample_t prim_a,
    input  sample_t prim_b,
    input  sample_t ref_in,
    output sample_t dout
);

    anc_ctrl_t  ctrl;
    prim_pair_t prim_in;
    sample_t    ref_taps [`ANC_TAPS];
    prim_pair_t prim_taps [`ANC_PRIM_DELAY];
    acc_t       acc_a;
    acc_t       acc_b;
    err_pair_t  err;

    assign prim_in = '{a: prim_a, b: prim_b};

    frame_sequencer u_seq (
        .clk       (clk),
        .rstn      (rstn),
        .head_flag (head_flag),
        .ctrl      (ctrl)
    );

    tap_delay_line #(.elem_t(sample_t), .DEPTH(`ANC_TAPS)) u_ref_line (
        .clk   (clk),
        .rstn  (rstn),
        .shift (ctrl.shift),
        .din   (ref_in),
        .taps  (ref_taps)
    );

    // The primary line advances at the ERROR edge, after its oldest entry has been used,
    // so that entry is exactly ANC_PRIM_DELAY frames old when the error is formed
    tap_delay_line #(.elem_t(prim_pair_t), .DEPTH(`ANC_PRIM_DELAY)) u_prim_line (
        .clk   (clk),
        .rstn  (rstn),
        .shift (ctrl.latch_err),
        .din   (prim_in),
        .taps  (prim_taps)
    );

    lms_channel u_chan_a (
        .clk      (clk),
        .rstn     (rstn),
        .ctrl     (ctrl),
        .ref_taps (ref_taps),
        .err      (err.a),
        .acc      (acc_a)
    );

    lms_channel u_chan_b (
        .clk      (clk),
        .rstn     (rstn),
        .ctrl     (ctrl),
        .ref_taps (ref_taps),
        .err      (err.b),
        .acc      (acc_b)
    );

    cancel_output u_out (
        .clk       (clk),
        .rstn      (rstn),
        .latch_err (ctrl.latch_err),
        .acc_a     (acc_a),
        .acc_b     (acc_b),
        .prim_del  (prim_taps[`ANC_PRIM_DELAY-1]),
        .err       (err),
        .dout      (dout)
    );

endmodule

// File: logic/cancel_output.sv
`timescale 1ns/1ps
`include "anc_defines.svh"

module cancel_output import anc_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       latch_err,
    input  acc_t       acc_a,
    input  acc_t       acc_b,
    input  prim_pair_t prim_del,
    output err_pair_t  err,
    output sample_t    dout
);

    sample_t err_a_nxt;
    sample_t err_b_nxt;

    // Scales a finished accumulator back to a sample and removes it from the primary
    function automatic sample_t cancel_sample(input acc_t acc, input sample_t prim);
        sample_t y;
        y = sample_t'(acc >>> `ANC_W_FRAC);
        return prim - y;
    endfunction

    assign err_a_nxt = cancel_sample(acc_a, prim_del.a);
    assign err_b_nxt = cancel_sample(acc_b, prim_del.b);

    // Everything here changes only at the ERROR edge
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            err  <= '0;
            dout <= '0;
        end
        else if (latch_err)
        begin
            err.a <= err_a_nxt;
            err.b <= err_b_nxt;
            dout  <= err_a_nxt + err_b_nxt;  // Wraps to the sample width
        end
    end

endmodule

// File: logic/lms_channel.sv
`timescale 1ns/1ps
`include "anc_defines.svh"

module lms_channel import anc_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  anc_ctrl_t ctrl,
    input  sample_t   ref_taps [`ANC_TAPS],
    input  sample_t   err,
    output acc_t      acc
);

    localparam int PROD_W = `ANC_WEIGHT_W + `ANC_SAMPLE_W;
    localparam int STEP_W = 2 * `ANC_SAMPLE_W;

    weight_t                  w_mem [`ANC_TAPS];
    weight_t                  w_sel;
    sample_t                  x_sel;
    logic signed [PROD_W-1:0] mac_prod;
    logic signed [STEP_W-1:0] err_prod;
    weight_t                  w_step;

    // One tap per cycle, FILTER and ADAPT walk the same index
    assign w_sel = w_mem[ctrl.tap_idx];
    assign x_sel = ref_taps[ctrl.tap_idx];

    assign mac_prod = w_sel * x_sel;  // Full precision, no rounding
    assign err_prod = err * x_sel;

    // mu * e * x as an arithmetic shift, sign extended onto the weight width
    assign w_step = weight_t'(err_prod >>> `ANC_MU_SHIFT);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            acc <= '0;
        end
        else if (ctrl.clear_acc)
        begin
            acc <= '0;
        end
        else if (ctrl.mac_en)
        begin
            acc <= acc + mac_prod;
        end
    end

    // err holds the value latched in ERROR for the whole ADAPT phase
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < `ANC_TAPS; i++)
            begin
                w_mem[i] <= '0;
            end
        end
        else if (ctrl.adapt_en)
        begin
            w_mem[ctrl.tap_idx] <= w_sel + w_step;  // Wraps at the weight width
        end
    end

endmodule

// File: logic/tap_delay_line.sv
`timescale 1ns/1ps
`include "anc_defines.svh"

module tap_delay_line import anc_pkg::*;
#(
    parameter type elem_t = sample_t,
    parameter int  DEPTH  = `ANC_TAPS
)
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  shift,
    input  elem_t din,
    output elem_t taps [DEPTH]
);

    // Index 0 is the newest entry, DEPTH-1 the oldest
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                taps[i] <= '0;
            end
        end
        else if (shift)
        begin
            taps[0] <= din;
            for (int i = 1; i < DEPTH; i++)
            begin
                taps[i] <= taps[i-1];
            end
        end
    end

endmodule

// File: logic/frame_sequencer.sv
`timescale 1ns/1ps
`include "anc_defines.svh"

module frame_sequencer import anc_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      head_flag,
    output anc_ctrl_t ctrl
);

    localparam logic [`ANC_IDX_W-1:0] LAST_IDX = `ANC_IDX_W'(`ANC_TAPS - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_FILTER,
        S_ERROR,
        S_ADAPT,
        S_HOLD
    } state_t;

    state_t                state;
    state_t                state_nxt;
    logic [`ANC_IDX_W-1:0] phase_cnt;
    logic [`ANC_IDX_W-1:0] phase_cnt_nxt;
    anc_ctrl_t             ctrl_nxt;

    // FILTER and ADAPT share the phase counter, both run from tap 0 to the last tap
    always_comb
    begin
        state_nxt     = state;
        phase_cnt_nxt = phase_cnt;
        case (state)
            S_IDLE:   if (head_flag) state_nxt = S_LOAD;
            S_LOAD:
            begin
                state_nxt     = S_FILTER;
                phase_cnt_nxt = '0;
            end
            S_FILTER:
            begin
                phase_cnt_nxt = phase_cnt + 1'b1;
                if (phase_cnt == LAST_IDX)
                begin
                    state_nxt     = S_ERROR;
                    phase_cnt_nxt = '0;
                end
            end
            S_ERROR:  state_nxt = S_ADAPT;
            S_ADAPT:
            begin
                phase_cnt_nxt = phase_cnt + 1'b1;
                if (phase_cnt == LAST_IDX)
                begin
                    state_nxt     = head_flag ? S_HOLD : S_IDLE;  // Skip HOLD once the flag is down
                    phase_cnt_nxt = '0;
                end
            end
            S_HOLD:   if (!head_flag) state_nxt = S_IDLE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    // Strobes are decoded from the next state so they line up with the state register
    always_comb
    begin
        ctrl_nxt.shift     = (state_nxt == S_LOAD);
        ctrl_nxt.clear_acc = (state_nxt == S_LOAD);
        ctrl_nxt.mac_en    = (state_nxt == S_FILTER);
        ctrl_nxt.latch_err = (state_nxt == S_ERROR);
        ctrl_nxt.adapt_en  = (state_nxt == S_ADAPT);
        ctrl_nxt.tap_idx   = phase_cnt_nxt;
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state     <= S_IDLE;
            phase_cnt <= '0;
            ctrl      <= '0;
        end
        else
        begin
            state     <= state_nxt;
            phase_cnt <= phase_cnt_nxt;
            ctrl      <= ctrl_nxt;
        end
    end

endmodule

// File: logic/anc_pkg.sv
`include "anc_defines.svh"

package anc_pkg;

    typedef logic signed [`ANC_SAMPLE_W-1:0] sample_t;
    typedef logic signed [`ANC_WEIGHT_W-1:0] weight_t;
    typedef logic signed [`ANC_ACC_W-1:0]    acc_t;

    // Primary samples of both channels, taken in the same frame
    typedef struct packed {
        sample_t a;
        sample_t b;
    } prim_pair_t;

    // Cancelled samples, held from one ERROR phase to the next
    typedef struct packed {
        sample_t a;
        sample_t b;
    } err_pair_t;

    // Decoded strobes from the frame sequencer
    typedef struct packed {
        logic                  shift;      // Push new samples into the delay lines
        logic                  clear_acc;  // Zero the accumulators before FILTER
        logic                  mac_en;     // FILTER phase
        logic                  latch_err;  // ERROR phase
        logic                  adapt_en;   // ADAPT phase
        logic [`ANC_IDX_W-1:0] tap_idx;    // Tap handled in this cycle
    } anc_ctrl_t;

endpackage

// File: include/anc_defines.svh
`ifndef ANC_DEFINES_SVH
`define ANC_DEFINES_SVH

// Filter length and sample format
`define ANC_TAPS        32
`define ANC_SAMPLE_W    14
`define ANC_IDX_W       5

// Weights are Q15.16 in two's complement
`define ANC_WEIGHT_W    32
`define ANC_W_FRAC      16

// Holds 32 products of 46 bits without overflow
`define ANC_ACC_W       52

`define ANC_MU_SHIFT    12  // Step size as a power of two

`define ANC_PRIM_DELAY  16  // Primary alignment in frames, half the tap count

`endif
